//--- Makefile
VERILATOR ?= verilator
FILELIST  := vlog.f
TOP       := cpuTb
RTL_TOP   := mipsCpuBus
VFLAGS    := --timing --assert
OBJDIR    := obj_dir

RTL_FILES := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- rtl/aluExecute.sv
////////////////////////////////////////////////////////////////////////////
// Shifts act on rt; variable shifts take rs[4:0]
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module aluExecute import mipsPkg::*; (
    input  wordT                rsData,
    input  wordT                rtData,
    input  logic [4:0]          shamt,
    input  logic [ImmWidth-1:0] imm,
    input  aluOpT               aluOp,
    input  logic                useImm,
    input  logic                signExtImm,
    output wordT                aluResult,
    output logic                operandsEqual
);

    wordT       immExt;
    wordT       opB;
    logic [4:0] varShift;

    // Immediate extension, logical ops use zero extension
    assign immExt = signExtImm ? {{(WordWidth-ImmWidth){imm[ImmWidth-1]}}, imm}
                               : {{(WordWidth-ImmWidth){1'b0}}, imm};

    assign opB      = useImm ? immExt : rtData;
    assign varShift = rsData[4:0];

    // Branch compare always on the two registers
    assign operandsEqual = (rsData == rtData);

    always_comb begin
        case (aluOp)
            AluAdd:  aluResult = rsData + opB; // Also load/store address
            AluSub:  aluResult = rsData - opB;
            AluAnd:  aluResult = rsData & opB;
            AluOr:   aluResult = rsData | opB;
            AluXor:  aluResult = rsData ^ opB;
            AluSlt: begin
                aluResult = ($signed(rsData) < $signed(opB)) ? 32'd1 : 32'd0;
            end
            AluSltu: begin
                aluResult = (rsData < opB) ? 32'd1 : 32'd0;
            end
            AluSll:  aluResult = rtData << shamt;
            AluSrl:  aluResult = rtData >> shamt;
            AluSra:  aluResult = wordT'($signed(rtData) >>> shamt);
            AluSllv: aluResult = rtData << varShift;
            AluSrlv: aluResult = rtData >> varShift;
            AluSrav: aluResult = wordT'($signed(rtData) >>> varShift);
            AluLui:  aluResult = {imm, {(WordWidth-ImmWidth){1'b0}}};
            default: aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/cpuControl.sv
////////////////////////////////////////////////////////////////////////////
// Registered Avalon outputs, one access outstanding; halt only via reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpuControl import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic waitrequest,
    input  wordT readdata,
    input  logic isLoad,
    input  logic isStore,
    input  logic writesReg,
    input  wordT aluResult,   // Memory address for LW/SW
    input  wordT rtData,      // Store data
    input  wordT nextPc,
    output wordT instr,
    output wordT pc,
    output logic regWrite,
    output logic read,
    output logic write,
    output wordT address,
    output wordT writedata,
    output logic active
);

    cpuStateT state;
    logic     memOp;
    logic     retire;

    assign memOp = isLoad || isStore;

    // Last cycle of an instruction: end of Exec or a completed Mem access
    assign retire = ((state == Exec) && !memOp) ||
                    ((state == Mem) && !waitrequest);

    assign regWrite = retire && writesReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= Fetch;
            pc     <= ResetVector;
            active <= 1'b1;
            read   <= 1'b0;
            write  <= 1'b0;
        end else begin
            case (state)
                Fetch: begin
                    if (!read) begin
                        read    <= 1'b1;       // First fetch after reset
                        address <= pc;
                    end else if (!waitrequest) begin
                        instr <= readdata;     // Fetch accepted
                        read  <= 1'b0;
                        state <= Exec;
                    end
                end
                Exec: begin
                    if (memOp) begin
                        state     <= Mem;
                        read      <= isLoad;
                        write     <= isStore;
                        address   <= aluResult;
                        writedata <= rtData;
                    end
                end
                default: ; // Mem completes in the retire path, Halt stays put
            endcase

            if (retire) begin
                pc    <= nextPc;
                write <= 1'b0;
                if (nextPc == '0) begin
                    state  <= Halt;
                    active <= 1'b0;
                    read   <= 1'b0;
                end else begin
                    state   <= Fetch;
                    read    <= 1'b1;          // Next fetch issued right away
                    address <= nextPc;
                end
            end
        end
    end

    // Avalon master never reads and writes at once
    noReadWrite: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

    // Stalled transfer keeps its request and address
    holdOnWait: assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=>
            ($stable(address) && $stable(read) && $stable(write)));

endmodule

`default_nettype wire

//--- rtl/instrDecoder.sv
////////////////////////////////////////////////////////////////////////////
// Pure decode of the held instruction; unknown encodings act as no-ops
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import mipsPkg::*; (
    input  wordT                  instr,
    output regAddrT               rs,
    output regAddrT               rt,
    output regAddrT               rd,
    output logic [4:0]            shamt,
    output logic [ImmWidth-1:0]   imm,
    output logic [IndexWidth-1:0] jumpIndex,
    output aluOpT                 aluOp,
    output logic                  useImm,        // Operand B from immediate
    output logic                  signExtImm,
    output logic                  isLoad,
    output logic                  isStore,
    output logic                  isBranch,
    output logic                  branchOnEqual, // BEQ vs BNE
    output logic                  isJump,
    output logic                  isJumpReg,
    output logic                  writesReg,
    output logic                  destIsRt       // I-type destination
);

    opcodeT opcode;
    functT  funct;

    // Field split
    assign opcode    = opcodeT'(instr[31:26]);
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign shamt     = instr[10:6];
    assign funct     = functT'(instr[5:0]);
    assign imm       = instr[15:0];
    assign jumpIndex = instr[25:0];

    always_comb begin
        // Defaults describe a no-op
        aluOp         = AluAdd;
        useImm        = 1'b0;
        signExtImm    = 1'b0;
        isLoad        = 1'b0;
        isStore       = 1'b0;
        isBranch      = 1'b0;
        branchOnEqual = 1'b0;
        isJump        = 1'b0;
        isJumpReg     = 1'b0;
        writesReg     = 1'b0;
        destIsRt      = 1'b0;
        case (opcode)
            OpR: begin
                writesReg = 1'b1; // Cleared again below for JR and unknown funct
                case (funct)
                    FnAddu:  aluOp = AluAdd;
                    FnSubu:  aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnXor:   aluOp = AluXor;
                    FnSlt:   aluOp = AluSlt;
                    FnSltu:  aluOp = AluSltu;
                    FnSll:   aluOp = AluSll;
                    FnSrl:   aluOp = AluSrl;
                    FnSra:   aluOp = AluSra;
                    FnSllv:  aluOp = AluSllv;
                    FnSrlv:  aluOp = AluSrlv;
                    FnSrav:  aluOp = AluSrav;
                    FnJr: begin
                        isJumpReg = 1'b1;
                        writesReg = 1'b0;
                    end
                    default: writesReg = 1'b0;
                endcase
            end
            OpJ:   isJump = 1'b1;
            OpJal: begin
                isJump    = 1'b1;
                writesReg = 1'b1;                // Link into $ra
            end
            OpBeq: begin
                isBranch      = 1'b1;
                branchOnEqual = 1'b1;
            end
            OpBne: isBranch = 1'b1;
            OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui, OpLw: begin
                useImm     = 1'b1;
                writesReg  = 1'b1;
                destIsRt   = 1'b1;
                signExtImm = (opcode == OpAddiu) || (opcode == OpSlti) ||
                             (opcode == OpSltiu) || (opcode == OpLw);
                isLoad     = (opcode == OpLw);
                case (opcode)
                    OpSlti:  aluOp = AluSlt;
                    OpSltiu: aluOp = AluSltu;
                    OpAndi:  aluOp = AluAnd;
                    OpOri:   aluOp = AluOr;
                    OpXori:  aluOp = AluXor;
                    OpLui:   aluOp = AluLui;
                    default: aluOp = AluAdd; // ADDIU and LW address
                endcase
            end
            OpSw: begin
                isStore    = 1'b1;
                useImm     = 1'b1;
                signExtImm = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mipsCpuBus.sv
////////////////////////////////////////////////////////////////////////////
// Word accesses only, byteenable fixed at all ones
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mipsCpuBus import mipsPkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output wordT       register_v0,
    output wordT       address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output wordT       writedata,
    output logic [3:0] byteenable,
    input  wordT       readdata
);

    wordT                  instr, pc, nextPc;
    wordT                  rsData, rtData, aluResult, wrData;
    regAddrT               rs, rt, rd, wrAddr;
    logic [4:0]            shamt;
    logic [ImmWidth-1:0]   imm;
    logic [IndexWidth-1:0] jumpIndex;
    aluOpT                 aluOp;
    logic                  useImm, signExtImm, isLoad, isStore;
    logic                  isBranch, branchOnEqual, isJump, isJumpReg;
    logic                  writesReg, destIsRt, operandsEqual, regWrite;

    assign byteenable = 4'b1111;

    cpuControl control (
        .clk, .reset, .waitrequest, .readdata, .isLoad, .isStore, .writesReg,
        .aluResult, .rtData, .nextPc, .instr, .pc, .regWrite, .read, .write,
        .address, .writedata, .active
    );

    instrDecoder decoder (
        .instr, .rs, .rt, .rd, .shamt, .imm, .jumpIndex, .aluOp, .useImm,
        .signExtImm, .isLoad, .isStore, .isBranch, .branchOnEqual, .isJump,
        .isJumpReg, .writesReg, .destIsRt
    );

    regFile regs (
        .clk, .reset, .rs, .rt, .wrAddr, .wrData, .regWrite, .rsData, .rtData,
        .v0Data(register_v0)
    );

    aluExecute alu (
        .rsData, .rtData, .shamt, .imm, .aluOp, .useImm, .signExtImm,
        .aluResult, .operandsEqual
    );

    retireUnit retirement (
        .pc, .rd, .rt, .jumpIndex, .imm, .isLoad, .isBranch, .branchOnEqual,
        .isJump, .isJumpReg, .writesReg, .destIsRt, .aluResult, .readdata,
        .operandsEqual, .rsData, .wrAddr, .wrData, .nextPc
    );

endmodule

`default_nettype wire

//--- rtl/mipsPkg.sv
////////////////////////////////////////////////////////////////////////////
// Word-only MIPS-I subset, no HI/LO and no delay slot
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package mipsPkg;

    localparam int WordWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int ImmWidth     = 16;
    localparam int IndexWidth   = 26; // J-type target field

    typedef logic [WordWidth-1:0]    wordT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    // Opcodes kept from the full ISA
    typedef enum logic [5:0] {
        OpR     = 6'd0,
        OpJ     = 6'd2,
        OpJal   = 6'd3,
        OpBeq   = 6'd4,
        OpBne   = 6'd5,
        OpAddiu = 6'd9,
        OpSlti  = 6'd10,
        OpSltiu = 6'd11,
        OpAndi  = 6'd12,
        OpOri   = 6'd13,
        OpXori  = 6'd14,
        OpLui   = 6'd15,
        OpLw    = 6'd35,
        OpSw    = 6'd43
    } opcodeT;

    // R-type function field
    typedef enum logic [5:0] {
        FnSll  = 6'd0,
        FnSrl  = 6'd2,
        FnSra  = 6'd3,
        FnSllv = 6'd4,
        FnSrlv = 6'd6,
        FnSrav = 6'd7,
        FnJr   = 6'd8,
        FnAddu = 6'd33,
        FnSubu = 6'd35,
        FnAnd  = 6'd36,
        FnOr   = 6'd37,
        FnXor  = 6'd38,
        FnSlt  = 6'd42,
        FnSltu = 6'd43
    } functT;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor,
        AluSlt, AluSltu,
        AluSll, AluSrl, AluSra,     // Shift by shamt
        AluSllv, AluSrlv, AluSrav,  // Shift by rs[4:0]
        AluLui
    } aluOpT;

    typedef enum logic [1:0] {Fetch, Exec, Mem, Halt} cpuStateT;

    localparam wordT    ResetVector = 32'hBFC00000;
    localparam regAddrT LinkReg     = 5'd31; // $ra
    localparam regAddrT V0Reg       = 5'd2;  // $v0

endpackage

`default_nettype wire

//--- rtl/regFile.sv
////////////////////////////////////////////////////////////////////////////
// Asynchronous reads, single write port; writes to $zero are dropped
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regAddrT rs,
    input  regAddrT rt,
    input  regAddrT wrAddr,
    input  wordT    wrData,
    input  logic    regWrite,
    output wordT    rsData,
    output wordT    rtData,
    output wordT    v0Data
);

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // $zero forced on read as well
    assign rsData = (rs == '0) ? '0 : regs[rs];
    assign rtData = (rt == '0) ? '0 : regs[rt];
    assign v0Data = regs[V0Reg]; // Exported for register_v0

    // A write aimed at $zero must leave it clear afterwards
    zeroRegHeld: assert property (@(posedge clk) disable iff (reset)
        (regWrite && (wrAddr == '0)) |=> (regs[0] == '0));

endmodule

`default_nettype wire

//--- rtl/retireUnit.sv
////////////////////////////////////////////////////////////////////////////
// No delay slot: targets are taken on the very next fetch
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module retireUnit import mipsPkg::*; (
    input  wordT                  pc,
    input  regAddrT               rd,
    input  regAddrT               rt,
    input  logic [IndexWidth-1:0] jumpIndex,
    input  logic [ImmWidth-1:0]   imm,
    input  logic                  isLoad,
    input  logic                  isBranch,
    input  logic                  branchOnEqual,
    input  logic                  isJump,
    input  logic                  isJumpReg,
    input  logic                  writesReg,
    input  logic                  destIsRt,
    input  wordT                  aluResult,
    input  wordT                  readdata,      // Load word, valid in Mem
    input  logic                  operandsEqual,
    input  wordT                  rsData,
    output regAddrT               wrAddr,
    output wordT                  wrData,
    output wordT                  nextPc
);

    wordT pcPlus4;
    wordT branchTarget;
    wordT jumpTarget;
    logic linking;
    logic takeBranch;

    assign pcPlus4 = pc + 32'd4;
    assign linking = isJump && writesReg; // JAL only

    // Writeback source and destination
    assign wrAddr = linking  ? LinkReg : (destIsRt ? rt : rd);
    assign wrData = linking  ? pcPlus4 :
                    isLoad   ? readdata : aluResult;

    // Word offset, relative to PC+4
    assign branchTarget = pcPlus4 + {{(WordWidth-ImmWidth-2){imm[ImmWidth-1]}}, imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00}; // Same 256 MB region
    assign takeBranch   = isBranch && (operandsEqual == branchOnEqual);

    always_comb begin
        if (isJumpReg) begin
            nextPc = rsData;       // JR, JR $0 halts the core
        end else if (isJump) begin
            nextPc = jumpTarget;
        end else if (takeBranch) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

`default_nettype wire

//--- tests/cpuTb.sv
////////////////////////////////////////////////////////////////////////////
// Random ALU program then fixed memory and branch tests; ends on JR $0
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpuTb import mipsPkg::*; ();

    localparam logic [31:0] Seed     = 32'h0c9cc9d9;
    localparam int          RandOps  = 40;           // Random ALU instructions
    localparam wordT        DataBase = 32'h0001_0000;

    logic       clk, reset, waitrequest;
    logic       active, read, write;
    wordT       register_v0, address, writedata, readdata;
    logic [3:0] byteenable;
    logic       wrSeen, badAccess;
    wordT       wrAddrSeen, wrDataSeen;

    logic [31:0] rng;
    wordT        prog [$];
    wordT        expAddrQ [$];
    wordT        expDataQ [$];
    wordT        refMem [wordT];
    wordT        expV0;
    int          refSteps, cycles, cycleLimit, stallRun;

    mipsCpuBus UUT (
        .clk, .reset, .active, .register_v0, .address, .write, .read,
        .waitrequest, .writedata, .byteenable, .readdata
    );

    tbMemory #(.DataBase(DataBase)) mem (
        .clk, .address, .read, .write, .writedata, .waitrequest, .readdata,
        .wrSeen, .wrAddrSeen, .wrDataSeen, .badAccess
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Encoders
    function automatic wordT rType(input int rs, rt, rd, sh, functT fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic wordT iType(input opcodeT op, input int rs, rt, input logic [15:0] im);
        return {op, 5'(rs), 5'(rt), im};
    endfunction

    function automatic wordT jType(input opcodeT op, input wordT target);
        return {op, target[27:2]};
    endfunction

    function automatic wordT here(input int ahead);
        return ResetVector + 4 * (prog.size() + ahead);   // Address of a later slot
    endfunction

    task automatic buildProgram();
        functT  rOps [13];
        opcodeT iOps [7];
        logic [31:0] r;
        rOps = '{FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnSlt, FnSltu,
                 FnSll, FnSrl, FnSra, FnSllv, FnSrlv, FnSrav};
        iOps = '{OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui};
        for (int x = 1; x < 16; x++) begin     // Seed $1..$15
            prog.push_back(iType(OpLui, 0, x, 16'(nextRand())));
            prog.push_back(iType(OpOri, x, x, 16'(nextRand())));
        end
        for (int n = 0; n < RandOps; n++) begin
            r = nextRand();
            if (n % 2 == 0) begin              // Alternate R and I, cycling every op
                prog.push_back(rType(int'(r[8:5] | 4'd1), int'(r[12:9]), int'(r[16:13]),
                                     int'(r[21:17]), rOps[(n / 2) % 13]));
            end else begin                     // Dest 0..15, so $zero may be hit too
                prog.push_back(iType(iOps[(n / 2) % 7], int'(r[8:5]), int'(r[16:13]),
                                     16'(nextRand())));
            end
        end
        prog.push_back(rType(1, 2, 0, 0, FnAddu));              // Write aimed at $zero
        prog.push_back(iType(OpLui, 0, 20, DataBase[31:16]));   // $20 = data base
        for (int x = 0; x < 16; x++) begin
            prog.push_back(iType(OpSw, 20, x, 16'(4 * x)));
        end
        for (int k = 1; k < 5; k++) begin     // LW of stored word, then store it
            prog.push_back(iType(OpLw, 20, 16, 16'(4 * k)));
            prog.push_back(iType(OpSw, 20, 16, 16'(64 + 4 * k)));
        end
        prog.push_back(rType(16, 1, 17, 0, FnAddu));            // Dependent use
        prog.push_back(iType(OpSw, 20, 17, 16'd84));
        prog.push_back(iType(OpBeq, 1, 1, 16'd1));              // Taken
        prog.push_back(iType(OpSw, 20, 1, 16'd128));
        prog.push_back(iType(OpBne, 1, 1, 16'd1));              // Not taken
        prog.push_back(iType(OpSw, 20, 2, 16'd132));
        prog.push_back(iType(OpBne, 20, 0, 16'd1));             // Taken
        prog.push_back(iType(OpSw, 20, 3, 16'd136));
        prog.push_back(iType(OpBeq, 20, 0, 16'd1));             // Not taken
        prog.push_back(iType(OpSw, 20, 4, 16'd140));
        prog.push_back(iType(OpBne, 3, 4, 16'd1));              // Data dependent
        prog.push_back(iType(OpSw, 20, 5, 16'd144));
        prog.push_back(jType(OpJ, here(2)));                    // Skip one store
        prog.push_back(iType(OpSw, 20, 6, 16'd148));
        prog.push_back(jType(OpJal, here(4)));
        prog.push_back(iType(OpSw, 20, 31, 16'd152));           // Link value
        prog.push_back(iType(OpSw, 20, 2, 16'd156));
        prog.push_back(rType(0, 0, 0, 0, FnJr));                // Halt
        prog.push_back(iType(OpAddiu, 2, 2, 16'h8123));         // Subroutine
        prog.push_back(iType(OpSw, 20, 2, 16'd160));
        prog.push_back(rType(31, 0, 0, 0, FnJr));
    endtask

    // ISA model, fills the expected store queues and returns final $v0
    function automatic wordT runReference();
        wordT    regs [32];
        wordT    pc, pc4, npc, a, b, se, ze, res, ins;
        logic    wr;
        regAddrT dst;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        pc = ResetVector;
        refSteps = 0;
        while ((pc != '0) && (((pc - ResetVector) >> 2) < prog.size())) begin
            ins = prog[(pc - ResetVector) >> 2];
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            se  = {{16{ins[15]}}, ins[15:0]};
            ze  = {16'h0, ins[15:0]};
            pc4 = pc + 4;
            npc = pc4;
            wr  = 1'b1;
            dst = ins[20:16];
            res = '0;
            case (ins[31:26])
                OpR: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FnAddu: res = a + b;
                        FnSubu: res = a - b;
                        FnAnd:  res = a & b;
                        FnOr:   res = a | b;
                        FnXor:  res = a ^ b;
                        FnSlt:  res = ($signed(a) < $signed(b)) ? 1 : 0;
                        FnSltu: res = (a < b) ? 1 : 0;
                        FnSll:  res = b << ins[10:6];
                        FnSrl:  res = b >> ins[10:6];
                        FnSra:  res = $signed(b) >>> ins[10:6];
                        FnSllv: res = b << a[4:0];
                        FnSrlv: res = b >> a[4:0];
                        FnSrav: res = $signed(b) >>> a[4:0];
                        FnJr: begin
                            npc = a;
                            wr  = 1'b0;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OpAddiu: res = a + se;
                OpSlti:  res = ($signed(a) < $signed(se)) ? 1 : 0;
                OpSltiu: res = (a < se) ? 1 : 0;
                OpAndi:  res = a & ze;
                OpOri:   res = a | ze;
                OpXori:  res = a ^ ze;
                OpLui:   res = {ins[15:0], 16'h0};
                OpLw:    res = refMem.exists(a + se) ? refMem[a + se] : '0;
                OpSw: begin
                    expAddrQ.push_back(a + se);
                    expDataQ.push_back(b);
                    refMem[a + se] = b;
                    wr = 1'b0;
                end
                OpBeq, OpBne: begin
                    if ((a == b) == (ins[31:26] == OpBeq)) npc = pc4 + (se << 2);
                    wr = 1'b0;
                end
                OpJ, OpJal: begin
                    npc = {pc4[31:28], ins[25:0], 2'b00};
                    dst = LinkReg;
                    res = pc4;                      // Link value
                    wr  = (ins[31:26] == OpJal);
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dst != 0)) regs[dst] = res;
            pc = npc;
            refSteps++;
        end
        return regs[V0Reg];
    endfunction

    task automatic failRun(input string why);
        $display("%s at %0t", why, $time);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "store check failed");
        end
    endtask

    task automatic checkV0(input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("mismatch at %0t: register_v0 is %h, expected %h", $time, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "v0 check failed");
        end
    endtask

    // Waitrequest, about one cycle in three high, at most two in a row
    always @(negedge clk) begin : stallGen
        logic [31:0] draw;
        draw = nextRand();                      // One draw per cycle, reset or not
        if (reset || (stallRun >= 2) || (draw % 3 != 0)) begin
            waitrequest = 1'b0;
            stallRun    = 0;
        end else begin
            waitrequest = 1'b1;
            stallRun++;
        end
    end

    // Compare process, outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        wordT ea;
        wordT ed;
        if (!reset) begin
            cycles++;
            if (cycles > cycleLimit) failRun("timeout, the core did not halt");
            if (read && write) failRun("read and write high together");
            if (badAccess) failRun("bus access outside the modeled memory");
            if ((read || write) && (byteenable != 4'hf)) failRun("byteenable not all ones");
            if (!active && (read || write)) failRun("bus access after halt");
            if (wrSeen) begin
                if (expAddrQ.size() == 0) failRun("store that the reference never made");
                ea = expAddrQ.pop_front();
                ed = expDataQ.pop_front();
                checkWord(wrAddrSeen, ea, "store address");
                checkWord(wrDataSeen, ed, "store data");
            end
        end
    end

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b0;
        rng         = Seed;
        cycles      = 0;
        stallRun    = 0;
        buildProgram();
        expV0      = runReference();
        cycleLimit = refSteps * 3 * 4 + 100;    // Worst stall factor plus margin
        @(negedge clk);                         // Memory model cleared by now
        for (int i = 0; i < prog.size(); i++) begin
            mem.writeProgram(i, prog[i]);
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        while (active !== 1'b0) @(negedge clk);
        repeat (10) @(negedge clk);             // Bus must stay idle
        if (active !== 1'b0) failRun("active rose again after halt");
        checkV0(register_v0, expV0);
        if (expAddrQ.size() != 0) begin
            failRun("stores missing at halt");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/tbMemory.sv
////////////////////////////////////////////////////////////////////////////
// Zero-latency Avalon slave, program at ResetVector and one data window
// Accesses outside both windows raise badAccess, which stays set
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tbMemory import mipsPkg::*; #(
    parameter wordT DataBase = 32'h0001_0000,
    parameter int   ProgWords = 256,
    parameter int   DataWords = 64
) (
    input  logic clk,
    input  wordT address,
    input  logic read,
    input  logic write,
    input  wordT writedata,
    input  logic waitrequest,   // Driven by the testbench
    output wordT readdata,
    output logic wrSeen,        // One cycle per completed write
    output wordT wrAddrSeen,
    output wordT wrDataSeen,
    output logic badAccess
);

    wordT progMem [ProgWords];
    wordT dataMem [DataWords];
    logic inProg;
    logic inData;

    assign inProg = (address >= ResetVector) && (address < ResetVector + 4 * ProgWords);
    assign inData = (address >= DataBase) && (address < DataBase + 4 * DataWords);

    // Combinational read, sampled by the DUT when waitrequest is low
    assign readdata = inProg ? progMem[(address - ResetVector) >> 2] :
                      inData ? dataMem[(address - DataBase) >> 2] : '0;

    initial begin
        wrSeen    = 1'b0;
        badAccess = 1'b0;
        for (int i = 0; i < DataWords; i++) begin
            // Fill depends on every address bit
            dataMem[i] = ~(DataBase + 4 * i) ^ {16'h5a5a, 16'(i * 4)};
        end
        for (int i = 0; i < ProgWords; i++) begin
            progMem[i] = '0;
        end
    end

    // Program image loader, called before reset ends
    task automatic writeProgram(input int idx, input wordT word);
        progMem[idx] = word;
    endtask

    always @(posedge clk) begin
        wrSeen <= 1'b0;
        if ((read || write) && !inProg && !inData) begin
            badAccess <= 1'b1;
        end
        if (write && !waitrequest && inData) begin
            dataMem[(address - DataBase) >> 2] <= writedata;
            wrSeen     <= 1'b1;                 // Store monitor
            wrAddrSeen <= address;
            wrDataSeen <= writedata;
        end else if (write && !waitrequest) begin
            badAccess <= 1'b1;                  // Write into program space
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/mipsPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/aluExecute.sv
rtl/retireUnit.sv
rtl/cpuControl.sv
rtl/mipsCpuBus.sv
tests/tbMemory.sv
tests/cpuTb.sv
